/* logic/sw_hdr_pkg.sv */
package sw_hdr_pkg;

    // header geometry
    localparam int BYTE_W    = 8;
    localparam int HDR_LEN   = 8;
    localparam int NUM_PORTS = 4;

    // byte of the header that carries the lookup key
    localparam int KEY_BYTE  = 1;

    typedef logic [BYTE_W - 1:0] byte_t;

    // byte 0 sits in the low bits
    typedef byte_t [HDR_LEN - 1:0] hdr_t;

    // all zero means drop
    typedef logic [NUM_PORTS - 1:0] port_mask_t;

    // header plus the ports it leaves on
    typedef struct packed {
        hdr_t       hdr;
        port_mask_t port;
    } pkt_item_t;

endpackage

/* logic/sw_ft_pkg.sv */
package sw_ft_pkg;

    // flow table geometry
    localparam int FT_DEPTH  = 16;
    localparam int FT_ADDR_W = 4;
    localparam int FT_TAG_W  = 4;
    localparam int FT_DATA_W = 16;

    // low nibble of the key byte
    typedef logic [FT_ADDR_W - 1:0] ft_addr_t;

    // compared against the high nibble of the key byte
    typedef logic [FT_TAG_W - 1:0] ft_tag_t;

    typedef struct packed {
        logic                   valid;
        ft_tag_t                tag;
        sw_hdr_pkg::port_mask_t mask;
    } ft_entry_t;

    localparam int FT_ENTRY_W = $bits(ft_entry_t);

    typedef logic [FT_DATA_W - 1:0] ft_data_t;

    // controller strobe port
    typedef struct packed {
        logic     ce;
        logic     we;
        ft_addr_t addr;
        ft_data_t wdata;
    } ctrl_req_t;

endpackage

/* logic/hdr_latch.sv */
module hdr_latch (
    input  logic                  clk,
    input  logic                  arst_n_i,
    // write side
    input  logic                  wr_i,
    input  sw_hdr_pkg::pkt_item_t item_i,
    // read side
    input  logic                  rd_i,
    output sw_hdr_pkg::pkt_item_t item_o,
    output logic                  empty_o
);

    logic full;
    logic wr_en;

    // a write into a full latch is dropped
    assign wr_en = wr_i && !full;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full <= 1'b0;
        end else if (wr_en) begin
            full <= 1'b1;
        end else if (rd_i) begin
            full <= 1'b0;
        end
    end

    // item stays visible after the read until overwritten
    always_ff @(posedge clk) begin
        if (wr_en) begin
            item_o <= item_i;
        end
    end

    assign empty_o = !full;

endmodule

/* logic/flow_table.sv */
module flow_table (
    input  logic                  clk,
    input  logic                  arst_n_i,
    // controller port
    input  sw_ft_pkg::ctrl_req_t  ctrl_req_i,
    output sw_ft_pkg::ft_data_t   ctrl_data_o,
    output logic                  ctrl_ready_o,
    // lookup port
    input  sw_ft_pkg::ft_addr_t   lookup_addr_i,
    output sw_ft_pkg::ft_entry_t  lookup_entry_o
);

    localparam int PAD_W = sw_ft_pkg::FT_DATA_W - sw_ft_pkg::FT_ENTRY_W;

    sw_ft_pkg::ft_entry_t table_q [sw_ft_pkg::FT_DEPTH];

    logic ctrl_wr;
    logic ctrl_rd;

    assign ctrl_wr = ctrl_req_i.ce && ctrl_req_i.we;
    assign ctrl_rd = ctrl_req_i.ce && !ctrl_req_i.we;

    // entries and the ready pulse
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < sw_ft_pkg::FT_DEPTH; i++) begin
                table_q[i] <= '0;
            end
            ctrl_ready_o <= 1'b0;
        end else begin
            ctrl_ready_o <= ctrl_req_i.ce;
            if (ctrl_wr) begin
                table_q[ctrl_req_i.addr] <= ctrl_req_i.wdata[sw_ft_pkg::FT_ENTRY_W - 1:0];
            end
        end
    end

    // controller read data, upper bits zero
    always_ff @(posedge clk) begin
        if (ctrl_rd) begin
            ctrl_data_o <= {{PAD_W{1'b0}}, table_q[ctrl_req_i.addr]};
        end
    end

    // registered lookup, sees the old entry on a same-cycle write
    always_ff @(posedge clk) begin
        lookup_entry_o <= table_q[lookup_addr_i];
    end

endmodule

/* logic/match_proc.sv */
module match_proc (
    input  logic                  clk,
    input  logic                  arst_n_i,
    // input latch
    input  logic                  in_empty_i,
    input  sw_hdr_pkg::pkt_item_t in_item_i,
    output logic                  in_rd_o,
    // flow table lookup
    output sw_ft_pkg::ft_addr_t   lookup_addr_o,
    input  sw_ft_pkg::ft_entry_t  lookup_entry_i,
    // output latch
    input  logic                  out_empty_i,
    output logic                  out_wr_o,
    output sw_hdr_pkg::pkt_item_t out_item_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_EMIT
    } state_e;

    state_e                state_q;
    state_e                state_d;
    sw_hdr_pkg::pkt_item_t item_q;
    sw_hdr_pkg::byte_t     in_key;
    sw_hdr_pkg::byte_t     held_key;
    sw_ft_pkg::ft_tag_t    held_tag;
    logic                  hit;

    // low nibble addresses the table straight from the latch
    assign in_key        = in_item_i.hdr[sw_hdr_pkg::KEY_BYTE];
    assign lookup_addr_o = in_key[3:0];

    // high nibble of the captured key
    assign held_key = item_q.hdr[sw_hdr_pkg::KEY_BYTE];
    assign held_tag = held_key[7:4];

    assign hit = lookup_entry_i.valid && (lookup_entry_i.tag == held_tag);

    always_comb begin
        state_d  = state_q;
        in_rd_o  = 1'b0;
        out_wr_o = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (!in_empty_i) begin
                    in_rd_o = 1'b1;
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                state_d = ST_EMIT;
            end
            ST_EMIT: begin
                // wait for room downstream
                if (out_empty_i) begin
                    out_wr_o = 1'b1;
                    state_d  = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture, then overwrite the mask once the entry is back
    always_ff @(posedge clk) begin
        if (in_rd_o) begin
            item_q <= in_item_i;
        end else if (state_q == ST_LOOKUP) begin
            item_q.port <= hit ? lookup_entry_i.mask : '0;
        end
    end

    assign out_item_o = item_q;

endmodule

/* logic/switch_top.sv */
module switch_top (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // switch input
    input  logic                   sw_wr_i,
    input  sw_hdr_pkg::hdr_t       sw_hdr_i,
    output logic                   sw_in_empty_o,
    // switch output
    input  logic                   sw_rd_i,
    output sw_hdr_pkg::hdr_t       sw_hdr_o,
    output sw_hdr_pkg::port_mask_t sw_port_o,
    output logic                   sw_out_empty_o,
    // flow table access by controller
    input  sw_ft_pkg::ctrl_req_t   ctrl_req_i,
    output sw_ft_pkg::ft_data_t    ctrl_data_o,
    output logic                   ctrl_ready_o
);

    sw_hdr_pkg::pkt_item_t in_item;
    sw_hdr_pkg::pkt_item_t proc_in_item;
    sw_hdr_pkg::pkt_item_t proc_out_item;
    sw_hdr_pkg::pkt_item_t out_item;
    logic                  proc_in_rd;
    logic                  proc_out_wr;
    sw_ft_pkg::ft_addr_t   lookup_addr;
    sw_ft_pkg::ft_entry_t  lookup_entry;

    // headers enter with no ports assigned
    assign in_item.hdr  = sw_hdr_i;
    assign in_item.port = '0;

    hdr_latch u_in_latch (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (sw_wr_i),
        .item_i   (in_item),
        .rd_i     (proc_in_rd),
        .item_o   (proc_in_item),
        .empty_o  (sw_in_empty_o)
    );

    match_proc u_match_proc (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .in_empty_i     (sw_in_empty_o),
        .in_item_i      (proc_in_item),
        .in_rd_o        (proc_in_rd),
        .lookup_addr_o  (lookup_addr),
        .lookup_entry_i (lookup_entry),
        .out_empty_i    (sw_out_empty_o),
        .out_wr_o       (proc_out_wr),
        .out_item_o     (proc_out_item)
    );

    flow_table u_flow_table (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .ctrl_req_i     (ctrl_req_i),
        .ctrl_data_o    (ctrl_data_o),
        .ctrl_ready_o   (ctrl_ready_o),
        .lookup_addr_i  (lookup_addr),
        .lookup_entry_o (lookup_entry)
    );

    hdr_latch u_out_latch (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wr_i     (proc_out_wr),
        .item_i   (proc_out_item),
        .rd_i     (sw_rd_i),
        .item_o   (out_item),
        .empty_o  (sw_out_empty_o)
    );

    assign sw_hdr_o  = out_item.hdr;
    assign sw_port_o = out_item.port;

endmodule

/* testbench/switch_checker.sv */
module switch_checker (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // switch input side
    input  logic                   in_wr_i,
    input  sw_hdr_pkg::hdr_t       in_hdr_i,
    input  logic                   in_empty_i,
    // switch output side
    input  logic                   out_rd_i,
    input  sw_hdr_pkg::hdr_t       out_hdr_i,
    input  sw_hdr_pkg::port_mask_t out_port_i,
    input  logic                   out_empty_i,
    // controller port
    input  sw_ft_pkg::ctrl_req_t   ctrl_req_i,
    input  sw_ft_pkg::ft_data_t    ctrl_data_i,
    input  logic                   ctrl_ready_i,
    // results
    output int                     err_count_o,
    output int                     check_count_o,
    output int                     pending_o
);
    timeunit 1ns;
    timeprecision 100ps;

    sw_ft_pkg::ft_entry_t  mirror [sw_ft_pkg::FT_DEPTH];
    sw_hdr_pkg::pkt_item_t expect_q [$];
    logic                  prev_ce;
    logic                  prev_rd;
    sw_ft_pkg::ft_data_t   prev_rdata;
    logic                  reset_seen;
    int                    errors;
    int                    checks;

    // mask the switch should attach, from the mirrored table
    function automatic sw_hdr_pkg::port_mask_t expected_mask(input sw_hdr_pkg::hdr_t hdr);
        sw_hdr_pkg::byte_t    key;
        sw_ft_pkg::ft_entry_t ent;
        key = hdr[sw_hdr_pkg::KEY_BYTE];
        ent = mirror[key[3:0]];
        if (ent.valid && (ent.tag == key[7:4])) begin
            return ent.mask;
        end
        return '0;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        errors++;
    endtask

    initial begin
        errors     = 0;
        checks     = 0;
        prev_ce    = 1'b0;
        prev_rd    = 1'b0;
        prev_rdata = '0;
        reset_seen = 1'b0;
    end

    always @(posedge clk) begin
        sw_hdr_pkg::pkt_item_t item;
        sw_hdr_pkg::pkt_item_t head;
        if (!arst_n_i) begin
            for (int i = 0; i < sw_ft_pkg::FT_DEPTH; i++) begin
                mirror[i] = '0;
            end
            expect_q.delete();
            prev_ce    = 1'b0;
            prev_rd    = 1'b0;
            reset_seen = 1'b1;
        end else begin
            // first edge out of reset
            if (reset_seen) begin
                checks++;
                if (!in_empty_i || !out_empty_i || ctrl_ready_i) begin
                    report_mismatch($sformatf("after reset in_empty=%b out_empty=%b ready=%b",
                                              in_empty_i, out_empty_i, ctrl_ready_i));
                end
                reset_seen = 1'b0;
            end

            // one ready pulse, one cycle after each request
            if (prev_ce || ctrl_ready_i) begin
                checks++;
                if (ctrl_ready_i != prev_ce) begin
                    report_mismatch($sformatf("ready is %b, expected %b", ctrl_ready_i, prev_ce));
                end
            end
            if (prev_rd && ctrl_ready_i) begin
                checks++;
                if (ctrl_data_i !== prev_rdata) begin
                    report_mismatch($sformatf("table read data %h, expected %h",
                                              ctrl_data_i, prev_rdata));
                end
            end

            prev_ce = ctrl_req_i.ce;
            prev_rd = ctrl_req_i.ce && !ctrl_req_i.we;
            if (ctrl_req_i.ce && !ctrl_req_i.we) begin
                prev_rdata = '0;
                prev_rdata[sw_ft_pkg::FT_ENTRY_W - 1:0] = mirror[ctrl_req_i.addr];
            end
            if (ctrl_req_i.ce && ctrl_req_i.we) begin
                mirror[ctrl_req_i.addr] = ctrl_req_i.wdata[sw_ft_pkg::FT_ENTRY_W - 1:0];
            end

            // accepted header
            if (in_wr_i && in_empty_i) begin
                item.hdr  = in_hdr_i;
                item.port = expected_mask(in_hdr_i);
                expect_q.push_back(item);
            end

            // consumer read
            if (out_rd_i && !out_empty_i) begin
                if (expect_q.size() == 0) begin
                    $display("the switch put out a header that was never sent, at %0t", $time);
                    errors++;
                end else begin
                    head = expect_q.pop_front();
                    checks++;
                    if (out_hdr_i !== head.hdr) begin
                        report_mismatch($sformatf("header %h, expected %h", out_hdr_i, head.hdr));
                    end else if (out_port_i !== head.port) begin
                        report_mismatch($sformatf("port mask %b for header %h, expected %b",
                                                  out_port_i, out_hdr_i, head.port));
                    end
                end
            end
        end
    end

    assign err_count_o   = errors;
    assign check_count_o = checks;
    assign pending_o     = expect_q.size();

endmodule

/* testbench/tb_switch.sv */
module tb_switch;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 5;
    localparam int PKTS_DIRECT    = 40;
    localparam int PKTS_BACKPRESS = 48;
    localparam int REWRITES       = 6;
    localparam int PKTS_NEW_TABLE = 32;
    localparam int PAD_W          = sw_ft_pkg::FT_DATA_W - sw_ft_pkg::FT_ENTRY_W;
    // reset reads, write and read back, rewrites
    localparam int ACCESSES = 3 * sw_ft_pkg::FT_DEPTH + REWRITES;
    localparam int PACKETS  = PKTS_DIRECT + PKTS_BACKPRESS + PKTS_NEW_TABLE;
    localparam int CYCLE_LIMIT = 20 * (ACCESSES + PACKETS) + RESET_CYCLES;

    logic                   clk;
    logic                   arst_n;
    logic                   sw_wr;
    sw_hdr_pkg::hdr_t       sw_hdr_in;
    logic                   sw_in_empty;
    logic                   sw_rd;
    sw_hdr_pkg::hdr_t       sw_hdr_out;
    sw_hdr_pkg::port_mask_t sw_port;
    logic                   sw_out_empty;
    sw_ft_pkg::ctrl_req_t   ctrl_req;
    sw_ft_pkg::ft_data_t    ctrl_data;
    logic                   ctrl_ready;
    int                     err_count;
    int                     check_count;
    int                     pending;
    int                     errs_before;
    int                     cycle_count;
    logic                   leftover;
    logic [15:0]            lfsr_q = 16'd84;
    // tags written so far steer keys toward hits
    sw_ft_pkg::ft_tag_t     written_tag [sw_ft_pkg::FT_DEPTH];

    switch_top u_switch_top (
        .clk            (clk),
        .arst_n_i       (arst_n),
        .sw_wr_i        (sw_wr),
        .sw_hdr_i       (sw_hdr_in),
        .sw_in_empty_o  (sw_in_empty),
        .sw_rd_i        (sw_rd),
        .sw_hdr_o       (sw_hdr_out),
        .sw_port_o      (sw_port),
        .sw_out_empty_o (sw_out_empty),
        .ctrl_req_i     (ctrl_req),
        .ctrl_data_o    (ctrl_data),
        .ctrl_ready_o   (ctrl_ready)
    );

    switch_checker u_switch_checker (
        .clk           (clk),
        .arst_n_i      (arst_n),
        .in_wr_i       (sw_wr),
        .in_hdr_i      (sw_hdr_in),
        .in_empty_i    (sw_in_empty),
        .out_rd_i      (sw_rd),
        .out_hdr_i     (sw_hdr_out),
        .out_port_i    (sw_port),
        .out_empty_i   (sw_out_empty),
        .ctrl_req_i    (ctrl_req),
        .ctrl_data_i   (ctrl_data),
        .ctrl_ready_i  (ctrl_ready),
        .err_count_o   (err_count),
        .check_count_o (check_count),
        .pending_o     (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // fibonacci lfsr over x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[62:0], fb};
        end
        return val;
    endfunction

    // random header whose key tag matches the written one half the time
    function automatic sw_hdr_pkg::hdr_t make_hdr();
        sw_hdr_pkg::hdr_t    hdr;
        sw_ft_pkg::ft_addr_t addr;
        sw_ft_pkg::ft_tag_t  tag;
        hdr  = rand_bits(64);
        addr = sw_ft_pkg::ft_addr_t'(rand_bits(4));
        if (rand_bits(1) != 0) begin
            tag = written_tag[addr];
        end else begin
            tag = sw_ft_pkg::ft_tag_t'(rand_bits(4));
        end
        hdr[sw_hdr_pkg::KEY_BYTE] = {tag, addr};
        return hdr;
    endfunction

    task automatic ctrl_access(input logic we, input sw_ft_pkg::ft_addr_t addr,
                               input sw_ft_pkg::ft_data_t data);
        @(posedge clk);
        ctrl_req <= {1'b1, we, addr, data};
        @(posedge clk);
        ctrl_req <= '0;
        while (!ctrl_ready) @(posedge clk);
    endtask

    task automatic write_entry(input sw_ft_pkg::ft_addr_t addr, input logic valid,
                               input sw_ft_pkg::ft_tag_t tag);
        sw_ft_pkg::ft_entry_t ent;
        logic [PAD_W - 1:0]   pad;
        ent.valid = valid;
        ent.tag   = tag;
        ent.mask  = sw_hdr_pkg::port_mask_t'(rand_bits(sw_hdr_pkg::NUM_PORTS));
        // junk in the upper bits must not reach the table
        pad = PAD_W'(rand_bits(PAD_W));
        written_tag[addr] = tag;
        ctrl_access(1'b1, addr, {pad, ent});
    endtask

    task automatic send_pkt(input sw_hdr_pkg::hdr_t hdr);
        do @(posedge clk); while (!sw_in_empty);
        sw_wr     <= 1'b1;
        sw_hdr_in <= hdr;
        @(posedge clk);
        sw_wr <= 1'b0;
    endtask

    task automatic take_pkt(input int gap);
        repeat (gap) @(posedge clk);
        do @(posedge clk); while (sw_out_empty);
        sw_rd <= 1'b1;
        @(posedge clk);
        sw_rd <= 1'b0;
    endtask

    // headers and gaps drawn up front so both sides see a fixed order
    task automatic run_traffic(input int n, input int gap_bits);
        sw_hdr_pkg::hdr_t hdrs [$];
        int               gaps [$];
        for (int i = 0; i < n; i++) begin
            hdrs.push_back(make_hdr());
            gaps.push_back((gap_bits > 0) ? int'(rand_bits(gap_bits)) : 0);
        end
        fork
            begin
                foreach (hdrs[i]) send_pkt(hdrs[i]);
            end
            begin
                foreach (gaps[i]) take_pkt(gaps[i]);
            end
        join
    endtask

    task automatic report_test(input int num, input string name);
        @(negedge clk);
        $display("test %0d %s done: %0d errors", num, name, err_count - errs_before);
        errs_before = err_count;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

    initial begin
        arst_n    <= 1'b0;
        sw_wr     <= 1'b0;
        sw_hdr_in <= '0;
        sw_rd     <= 1'b0;
        ctrl_req  <= '0;
        errs_before = 0;
        leftover    = 1'b0;
        for (int i = 0; i < sw_ft_pkg::FT_DEPTH; i++) begin
            written_tag[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;

        for (int a = 0; a < sw_ft_pkg::FT_DEPTH; a++) begin
            ctrl_access(1'b0, sw_ft_pkg::ft_addr_t'(a), '0);
        end
        report_test(1, "reset state");

        for (int a = 0; a < sw_ft_pkg::FT_DEPTH; a++) begin
            write_entry(sw_ft_pkg::ft_addr_t'(a), 1'b1, sw_ft_pkg::ft_tag_t'(rand_bits(4)));
        end
        for (int a = 0; a < sw_ft_pkg::FT_DEPTH; a++) begin
            ctrl_access(1'b0, sw_ft_pkg::ft_addr_t'(a), '0);
        end
        report_test(2, "table write and read back");

        run_traffic(PKTS_DIRECT, 0);
        report_test(3, "lookup traffic");

        run_traffic(PKTS_BACKPRESS, 3);
        report_test(4, "back-pressure");

        // invalid entries keep their tag so a matching key still misses
        for (int k = 0; k < REWRITES; k++) begin
            sw_ft_pkg::ft_addr_t addr;
            addr = sw_ft_pkg::ft_addr_t'(rand_bits(4));
            if (k % 2 == 0) begin
                write_entry(addr, 1'b0, written_tag[addr]);
            end else begin
                write_entry(addr, 1'b1, sw_ft_pkg::ft_tag_t'(rand_bits(4)));
            end
        end
        run_traffic(PKTS_NEW_TABLE, 1);
        report_test(5, "rewritten table");

        if (pending != 0) begin
            $display("%0d sent headers never came out of the switch", pending);
            leftover = 1'b1;
        end
        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0 && !leftover) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/sw_hdr_pkg.sv
logic/sw_ft_pkg.sv
logic/hdr_latch.sv
logic/flow_table.sv
logic/match_proc.sv
logic/switch_top.sv
testbench/switch_checker.sv
testbench/tb_switch.sv

/* run_sim.sh */
#!/bin/sh
# build and run the switch testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -j 0 \
    --top-module tb_switch \
    -f vlog.f \
    -o tb_switch_sim

./obj_dir/tb_switch_sim | tee sim.log

# the log decides the result
if grep -q "^Verification passed$" sim.log; then
    echo "run_sim: simulation passed"
    exit 0
else
    echo "run_sim: simulation failed, see sim.log"
    exit 1
fi
